/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run from the project root, then check the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --top-module ucpd_regs_tb -f ucpd_regs.f -o ucpd_regs_sim &&
./obj_dir/ucpd_regs_sim > sim.log 2>&1 ||
echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && exit 0 || exit 1

/* tests/ucpd_regs_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_regs_tb;

  localparam int ADDR_W         = 6;
  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 16;
  localparam int SETTLE_CYCLES  = 6;   // Status path needs 4 edges
  localparam int MAX_LINES      = 64;
  localparam int LINE_CYCLES    = 8;   // Longest vector line with slack
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + MAX_LINES * LINE_CYCLES);

  logic                 pclk;
  logic                 presetn;
  logic                 wr_en;
  logic [ADDR_W-1:0]    reg_addr;
  ucpd_pkg::reg_word_t  pwdata;
  logic                 txhrst_clr;
  logic                 txsend_clr;
  logic                 frs_evt;
  ucpd_pkg::tx_status_t tx_status;
  ucpd_pkg::rx_status_t rx_status;
  ucpd_pkg::cc_comp_t   cc1_compout;
  ucpd_pkg::cc_comp_t   cc2_compout;
  ucpd_pkg::cfg_t       cfg;
  ucpd_pkg::ana_ctrl_t  ana_ctrl;
  ucpd_pkg::tx_ctrl_t   tx_ctrl;
  logic                 ucpd_intr;
  ucpd_pkg::reg_word_t  prdata;
  int                   cycle_cnt = 0;

  ucpd_regs #(
    .ADDR_W      (ADDR_W),
    .SYNC_STAGES (2)
  ) u_dut (
    .pclk        (pclk),
    .presetn     (presetn),
    .wr_en       (wr_en),
    .reg_addr    (reg_addr),
    .pwdata      (pwdata),
    .txhrst_clr  (txhrst_clr),
    .txsend_clr  (txsend_clr),
    .frs_evt     (frs_evt),
    .tx_status   (tx_status),
    .rx_status   (rx_status),
    .cc1_compout (cc1_compout),
    .cc2_compout (cc2_compout),
    .cfg         (cfg),
    .ana_ctrl    (ana_ctrl),
    .tx_ctrl     (tx_ctrl),
    .ucpd_intr   (ucpd_intr),
    .prdata      (prdata)
  );

  initial
  begin
    pclk = 1'b0;
    forever #(CLK_PERIOD/2) pclk = ~pclk;
  end

  // ----------------------------------------------------------
  // Failure handling and compare tasks
  // ----------------------------------------------------------
  task automatic fail_now();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input ucpd_pkg::reg_word_t got,
                            input ucpd_pkg::reg_word_t exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_ana(input string name, input ucpd_pkg::ana_ctrl_t got,
                           input ucpd_pkg::ana_ctrl_t exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got %03h expected %03h", $time, name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_cfg(input string name, input ucpd_pkg::cfg_t got,
                           input ucpd_pkg::cfg_t exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_tx(input string name, input ucpd_pkg::tx_ctrl_t got,
                          input ucpd_pkg::tx_ctrl_t exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_intr(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      fail_now();
    end
  endtask

  task automatic require_fields(input int got, input int want, input logic [7:0] op);
    if (got != want)
    begin
      $display("Vector line with opcode %s has %0d fields, needs %0d", op, got, want);
      fail_now();
    end
  endtask

  // CFG1 register layout
  function automatic ucpd_pkg::cfg_t unpack_cfg1(input ucpd_pkg::reg_word_t w);
    ucpd_pkg::cfg_t f;
    f.ucpden       = w[31];
    f.rx_ordset_en = w[28:20];
    f.psc_usbpdclk = w[19:17];
    f.transwin     = w[15:11];
    f.ifrgap       = w[10:6];
    f.hbitclkdiv   = w[5:0];
    return f;
  endfunction

  // TXMODE, TXSEND and TXHRST in CR
  function automatic ucpd_pkg::tx_ctrl_t unpack_cr_tx(input ucpd_pkg::reg_word_t w);
    ucpd_pkg::tx_ctrl_t t;
    t.tx_mode     = w[1:0];
    t.transmit_en = w[2];
    t.tx_hrst     = w[3];
    return t;
  endfunction

  // ----------------------------------------------------------
  // Drive tasks, each starts and ends on a falling edge
  // ----------------------------------------------------------
  task automatic write_reg(input logic [ADDR_W-1:0] addr, input ucpd_pkg::reg_word_t data);
    wr_en    = 1'b1;
    reg_addr = addr;
    pwdata   = data;
    @(negedge pclk);
    wr_en = 1'b0;
  endtask

  task automatic read_expect(input logic [ADDR_W-1:0] addr, input ucpd_pkg::reg_word_t exp);
    reg_addr = addr;
    #(CLK_PERIOD/4);  // Mid low phase
    check_word($sformatf("prdata[%0h]", addr), prdata, exp);
    // Level outputs follow the register just read
    if (addr == ADDR_W'(ucpd_pkg::CFG1_ADDR))
      check_cfg("cfg", cfg, unpack_cfg1(exp));
    if (addr == ADDR_W'(ucpd_pkg::CR_ADDR))
      check_tx("tx_ctrl", tx_ctrl, unpack_cr_tx(exp));
    @(negedge pclk);
  endtask

  task automatic pulse_clear(input logic [1:0] which);
    txsend_clr = which[0];
    txhrst_clr = which[1];
    @(negedge pclk);
    txsend_clr = 1'b0;
    txhrst_clr = 1'b0;
  endtask

  task automatic set_status(input logic [31:0] tx, input logic [31:0] rx,
                            input logic [31:0] frs, input logic [31:0] cc1,
                            input logic [31:0] cc2);
    tx_status   = ucpd_pkg::tx_status_t'(tx[5:0]);
    rx_status   = ucpd_pkg::rx_status_t'(rx[4:0]);
    frs_evt     = frs[0];
    cc1_compout = ucpd_pkg::cc_comp_t'(cc1[2:0]);
    cc2_compout = ucpd_pkg::cc_comp_t'(cc2[2:0]);
    repeat (SETTLE_CYCLES) @(negedge pclk);
  endtask

  always @(posedge pclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, vector run did not finish", TIMEOUT_CYCLES);
      fail_now();
    end
  end

  // ----------------------------------------------------------
  // Reset, then walk the vector file
  // ----------------------------------------------------------
  initial
  begin
    int                 fd;
    int                 code;
    logic [7:0]         op;
    logic [31:0]        f0;
    logic [31:0]        f1;
    logic [31:0]        f2;
    logic [31:0]        f3;
    logic [31:0]        f4;
    logic [8*128-1:0]   skip_line;
    presetn     = 1'b0;
    wr_en       = 1'b0;
    reg_addr    = '0;
    pwdata      = '0;
    txhrst_clr  = 1'b0;
    txsend_clr  = 1'b0;
    frs_evt     = 1'b0;
    tx_status   = '0;
    rx_status   = '0;
    cc1_compout = '0;  // Sink state 0
    cc2_compout = '0;
    repeat (RESET_CYCLES) @(negedge pclk);
    presetn = 1'b1;

    fd = $fopen("tests/ucpd_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open vector file tests/ucpd_vectors.txt");
      fail_now();
    end
    while ($fscanf(fd, "%s", op) == 1)
    begin
      case (op)
        "#": code = $fgets(skip_line, fd);
        "W":
        begin
          code = $fscanf(fd, "%h %h", f0, f1);
          require_fields(code, 2, op);
          write_reg(f0[ADDR_W-1:0], f1);
        end
        "S":
        begin
          code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
          require_fields(code, 5, op);
          set_status(f0, f1, f2, f3, f4);
        end
        "C":
        begin
          code = $fscanf(fd, "%h", f0);
          require_fields(code, 1, op);
          pulse_clear(f0[1:0]);
        end
        "R":
        begin
          code = $fscanf(fd, "%h %h", f0, f1);
          require_fields(code, 2, op);
          read_expect(f0[ADDR_W-1:0], f1);
        end
        "A":
        begin
          code = $fscanf(fd, "%h", f0);
          require_fields(code, 1, op);
          #(CLK_PERIOD/4);
          check_ana("ana_ctrl", ana_ctrl, ucpd_pkg::ana_ctrl_t'(f0[11:0]));
          @(negedge pclk);
        end
        "I":
        begin
          code = $fscanf(fd, "%h", f0);
          require_fields(code, 1, op);
          #(CLK_PERIOD/4);
          check_intr("ucpd_intr", ucpd_intr, f0[0]);
          @(negedge pclk);
        end
        default:
        begin
          $display("Unknown opcode %s in vector file", op);
          fail_now();
        end
      endcase
    end
    $fclose(fd);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/ucpd_vectors.txt */
# W addr data | R addr expected | S tx rx frs cc1 cc2 | C clr (1 send, 2 hrst)
# A expected ana_ctrl | I expected interrupt, all fields hex
R 00 00000000
R 03 00000000
R 04 00000000
R 05 00000000
A 000
I 0
W 00 00001234
R 00 00001234
W 03 00000010
W 00 80000000
R 00 80001234
R 03 00000000
A 02E
W 03 00100D6D
A D35
C 1
R 03 00100D69
C 2
R 03 00100D61
W 03 00000280
A 24E
S 00 00 0 0 0
R 05 0000C000
W 06 0000C000
R 06 00000000
W 04 00000004
S 02 00 0 0 0
S 00 10 1 0 0
R 05 00102004
I 1
W 06 00000004
R 05 00102000
I 0
W 06 00102000
S 00 00 0 3 7
R 05 000EC000
W 06 0000C000
W 03 00000000
S 00 00 0 1 7
R 05 0008C000
W 06 0000C000
S 00 00 0 3 7
R 05 00094000
W 03 00000C20
S 10 00 0 3 7
S 00 00 0 3 7
R 00 00001234
R 03 00000000
A 000
R 05 000EC020
I 0
W 04 FFFFFFFF
R 04 00000004

/* ucpd_regs.f */
verilog/ucpd_pkg.sv
verilog/ucpd_addr_decode.sv
verilog/ucpd_ctrl_regs.sv
verilog/ucpd_flag_sync.sv
verilog/ucpd_cc_vstate.sv
verilog/ucpd_status_regs.sv
verilog/ucpd_read_mux.sv
verilog/ucpd_regs.sv
tests/ucpd_regs_tb.sv

/* verilog/ucpd_addr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_addr_decode #(
  parameter int ADDR_W = 6
) (
  input  wire [ADDR_W-1:0]  reg_addr,
  input  wire               wr_en,
  output ucpd_pkg::reg_sel_t sel,
  output ucpd_pkg::reg_sel_t wr_sel
);

  // One-hot selects from the word address
  always_comb
  begin
    sel.cfg1 = (reg_addr == ADDR_W'(ucpd_pkg::CFG1_ADDR));
    sel.cr   = (reg_addr == ADDR_W'(ucpd_pkg::CR_ADDR));
    sel.imr  = (reg_addr == ADDR_W'(ucpd_pkg::IMR_ADDR));
    sel.sr   = (reg_addr == ADDR_W'(ucpd_pkg::SR_ADDR));
    sel.icr  = (reg_addr == ADDR_W'(ucpd_pkg::ICR_ADDR));
  end

  // Write strobes, SR is read only
  always_comb
  begin
    wr_sel      = ucpd_pkg::reg_sel_t'(sel & {$bits(sel){wr_en}});
    wr_sel.sr   = 1'b0;
  end

endmodule

`default_nettype wire

/* verilog/ucpd_cc_vstate.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_cc_vstate (
  input  wire                     pclk,
  input  wire                     presetn,
  input  wire ucpd_pkg::cc_comp_t comp,
  input  wire                     source_en,
  output ucpd_pkg::vstate_t       vstate,
  output logic                    change
);

  ucpd_pkg::vstate_t state_d;
  ucpd_pkg::vstate_t prev_q;
  logic              diff_q;
  logic              diff_d_q;

  // Thermometer code to CC voltage state
  always_comb
  begin
    if (source_en)
      case (comp)
        3'b001:  state_d = 2'd0;
        3'b011:  state_d = 2'd1;
        3'b111:  state_d = 2'd2;
        default: state_d = 2'd3;
      endcase
    else
      case (comp)
        3'b000:  state_d = 2'd0;
        3'b001:  state_d = 2'd1;
        3'b011:  state_d = 2'd2;
        3'b111:  state_d = 2'd3;
        default: state_d = 2'd0;
      endcase
  end

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
    begin
      vstate   <= '0;
      prev_q   <= '0;
      diff_q   <= 1'b0;
      diff_d_q <= 1'b0;
      change   <= 1'b0;
    end
    else
    begin
      vstate   <= state_d;
      prev_q   <= vstate;
      diff_q   <= (vstate != prev_q);
      diff_d_q <= diff_q;
      change   <= diff_q & ~diff_d_q;  // Rising edge of the compare
    end
  end

endmodule

`default_nettype wire

/* verilog/ucpd_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_ctrl_regs (
  input  wire                     pclk,
  input  wire                     presetn,
  input  wire ucpd_pkg::reg_sel_t wr_sel,
  input  wire ucpd_pkg::reg_word_t pwdata,
  input  wire                     txhrst_clr,
  input  wire                     txsend_clr,
  input  wire                     hard_rst,
  output ucpd_pkg::cfg_t          cfg,
  output ucpd_pkg::ana_ctrl_t     ana_ctrl,
  output ucpd_pkg::tx_ctrl_t      tx_ctrl,
  output ucpd_pkg::reg_word_t     cfg1_word,
  output ucpd_pkg::reg_word_t     cr_word,
  output ucpd_pkg::reg_word_t     imr_word
);

  // ----------------------------------------------------------
  // Register storage
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
    begin
      cfg1_word <= '0;
      cr_word   <= '0;
      imr_word  <= '0;
    end
    else
    begin
      if (hard_rst)
        cfg1_word[31] <= 1'b0;          // Hard reset drops the enable
      else if (wr_sel.cfg1)
      begin
        if (pwdata[31])
          cfg1_word[31] <= 1'b1;        // Enable only
        else
          cfg1_word[30:0] <= pwdata[30:0];
      end

      // CR held clear while the block is off
      if (!cfg.ucpden)
        cr_word <= '0;
      else if (wr_sel.cr)
        cr_word <= pwdata;
      else if (txhrst_clr)
        cr_word[3] <= 1'b0;
      else if (txsend_clr)
        cr_word[2] <= 1'b0;

      if (wr_sel.imr && cfg.ucpden)
        imr_word <= pwdata;
    end
  end

  // CFG1 field map
  assign cfg = {cfg1_word[31], cfg1_word[28:20], cfg1_word[19:17],
                cfg1_word[15:11], cfg1_word[10:6], cfg1_word[5:0]};

  // ----------------------------------------------------------
  // Analog decode, all gated by the enable
  // ----------------------------------------------------------
  always_comb
  begin
    ana_ctrl.phy_en      = cr_word[11:10] & {2{cfg.ucpden}};
    ana_ctrl.set_c500    = (cr_word[8:7] == 2'd1) & cfg.ucpden;
    ana_ctrl.set_c1500   = (cr_word[8:7] == 2'd2) & cfg.ucpden;
    ana_ctrl.set_c3000   = (cr_word[8:7] == 2'd3) & cfg.ucpden;
    ana_ctrl.set_pd      = cr_word[9] & cfg.ucpden;   // ANAMODE sink
    ana_ctrl.source_en   = ~cr_word[9] & cfg.ucpden;  // ANAMODE source
    ana_ctrl.phy_rx_en   = cr_word[5] & cfg.ucpden;
    ana_ctrl.cc1_det_en  = ~cr_word[20] & cfg.ucpden;
    ana_ctrl.cc2_det_en  = ~cr_word[21] & cfg.ucpden;
    ana_ctrl.phy_cc1_com = ~cr_word[6] & cfg.ucpden;
    ana_ctrl.phy_cc2_com = cr_word[6] & cfg.ucpden;
  end

  assign tx_ctrl = {cr_word[1:0], cr_word[2], cr_word[3]};

endmodule

`default_nettype wire

/* verilog/ucpd_flag_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_flag_sync #(
  parameter int  SYNC_STAGES = 2,
  parameter type payload_t   = logic
) (
  input  wire           pclk,
  input  wire           presetn,
  input  wire payload_t async_in,
  output payload_t      rise
);

  payload_t sync_q [SYNC_STAGES];
  payload_t dly_q;  // Previous synchronized value

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
        sync_q[i] <= '0;
      dly_q <= '0;
      rise  <= '0;
    end
    else
    begin
      sync_q[0] <= async_in;
      for (int i = 1; i < SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
      dly_q <= sync_q[SYNC_STAGES-1];
      rise  <= payload_t'(sync_q[SYNC_STAGES-1] & ~dly_q);  // 0 to 1 bits
    end
  end

endmodule

`default_nettype wire

/* verilog/ucpd_pkg.sv */
`default_nettype none

package ucpd_pkg;

  typedef logic [31:0] reg_word_t;

  // ----------------------------------------------------------
  // Word addresses, byte offset >> 2
  // ----------------------------------------------------------
  parameter int unsigned CFG1_ADDR = 0;  // 0x00
  parameter int unsigned CR_ADDR   = 3;  // 0x0C
  parameter int unsigned IMR_ADDR  = 4;  // 0x10
  parameter int unsigned SR_ADDR   = 5;  // 0x14
  parameter int unsigned ICR_ADDR  = 6;  // 0x18

  // SR field positions
  parameter int unsigned SR_TX_LO      = 1;
  parameter int unsigned SR_TX_HI      = 6;
  parameter int unsigned SR_RX_LO      = 9;
  parameter int unsigned SR_RX_HI      = 13;
  parameter int unsigned SR_TYPECEVT1  = 14;
  parameter int unsigned SR_TYPECEVT2  = 15;
  parameter int unsigned SR_VSTATE1_LO = 16;  // 17..16
  parameter int unsigned SR_VSTATE2_LO = 18;  // 19..18
  parameter int unsigned SR_FRSEVT     = 20;

  typedef struct packed {
    logic icr;
    logic sr;
    logic imr;
    logic cr;
    logic cfg1;
  } reg_sel_t;

  // CFG1 fields
  typedef struct packed {
    logic       ucpden;
    logic [8:0] rx_ordset_en;
    logic [2:0] psc_usbpdclk;
    logic [4:0] transwin;
    logic [4:0] ifrgap;
    logic [5:0] hbitclkdiv;
  } cfg_t;

  // Analog and PHY levels decoded from CR
  typedef struct packed {
    logic [1:0] phy_en;
    logic       set_c500;
    logic       set_c1500;
    logic       set_c3000;
    logic       set_pd;
    logic       source_en;
    logic       phy_rx_en;
    logic       cc1_det_en;
    logic       cc2_det_en;
    logic       phy_cc1_com;
    logic       phy_cc2_com;
  } ana_ctrl_t;

  typedef struct packed {
    logic [1:0] tx_mode;
    logic       transmit_en;
    logic       tx_hrst;
  } tx_ctrl_t;

  // PHY transmit events, SR bits 6..1
  typedef struct packed {
    logic underrun;
    logic hrst_sent;  // Also used as hard reset level
    logic hrst_disc;
    logic msg_abort;
    logic msg_sent;
    logic msg_disc;
  } tx_status_t;

  // PHY receive events, SR bits 13..9
  typedef struct packed {
    logic rx_err;
    logic msg_end;
    logic overrun;
    logic hrst_det;
    logic ordset_det;
  } rx_status_t;

  typedef logic [2:0] cc_comp_t;  // Thermometer code
  typedef logic [1:0] vstate_t;

endpackage

`default_nettype wire

/* verilog/ucpd_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_read_mux (
  input  wire ucpd_pkg::reg_sel_t  sel,
  input  wire ucpd_pkg::reg_word_t cfg1_word,
  input  wire ucpd_pkg::reg_word_t cr_word,
  input  wire ucpd_pkg::reg_word_t imr_word,
  input  wire ucpd_pkg::reg_word_t sr_word,
  output ucpd_pkg::reg_word_t      prdata,
  output logic                     ucpd_intr
);

  // ICR and unmapped offsets fall through to zero
  always_comb
  begin
    prdata = '0;
    case (1'b1)
      sel.cfg1: prdata = cfg1_word;
      sel.cr:   prdata = cr_word;
      sel.imr:  prdata = imr_word;
      sel.sr:   prdata = sr_word;
      default:  prdata = '0;
    endcase
  end

  // Any unmasked flag
  assign ucpd_intr = |(imr_word & sr_word);

endmodule

`default_nettype wire

/* verilog/ucpd_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_regs #(
  parameter int ADDR_W      = 6,
  parameter int SYNC_STAGES = 2
) (
  input  wire                       pclk,
  input  wire                       presetn,
  input  wire                       wr_en,
  input  wire [ADDR_W-1:0]          reg_addr,
  input  wire ucpd_pkg::reg_word_t  pwdata,
  input  wire                       txhrst_clr,
  input  wire                       txsend_clr,
  input  wire                       frs_evt,
  input  wire ucpd_pkg::tx_status_t tx_status,
  input  wire ucpd_pkg::rx_status_t rx_status,
  input  wire ucpd_pkg::cc_comp_t   cc1_compout,
  input  wire ucpd_pkg::cc_comp_t   cc2_compout,
  output ucpd_pkg::cfg_t            cfg,
  output ucpd_pkg::ana_ctrl_t       ana_ctrl,
  output ucpd_pkg::tx_ctrl_t        tx_ctrl,
  output logic                      ucpd_intr,
  output ucpd_pkg::reg_word_t       prdata
);

  ucpd_pkg::reg_sel_t   sel;
  ucpd_pkg::reg_sel_t   wr_sel;
  ucpd_pkg::reg_word_t  cfg1_word;
  ucpd_pkg::reg_word_t  cr_word;
  ucpd_pkg::reg_word_t  imr_word;
  ucpd_pkg::reg_word_t  sr_word;
  ucpd_pkg::tx_status_t tx_rise;
  ucpd_pkg::rx_status_t rx_rise;
  logic                 frs_rise;
  ucpd_pkg::vstate_t    cc1_vstate;
  ucpd_pkg::vstate_t    cc2_vstate;
  logic                 cc1_change;
  logic                 cc2_change;

  // ----------------------------------------------------------
  // Decode and control registers
  // ----------------------------------------------------------
  ucpd_addr_decode #(.ADDR_W(ADDR_W)) u_decode (
    .reg_addr (reg_addr),
    .wr_en    (wr_en),
    .sel      (sel),
    .wr_sel   (wr_sel)
  );

  ucpd_ctrl_regs u_ctrl (
    .pclk       (pclk),
    .presetn    (presetn),
    .wr_sel     (wr_sel),
    .pwdata     (pwdata),
    .txhrst_clr (txhrst_clr),
    .txsend_clr (txsend_clr),
    .hard_rst   (tx_status.hrst_sent),  // Raw level, not synchronized
    .cfg        (cfg),
    .ana_ctrl   (ana_ctrl),
    .tx_ctrl    (tx_ctrl),
    .cfg1_word  (cfg1_word),
    .cr_word    (cr_word),
    .imr_word   (imr_word)
  );

  // ----------------------------------------------------------
  // Status inputs
  // ----------------------------------------------------------
  ucpd_flag_sync #(
    .SYNC_STAGES (SYNC_STAGES),
    .payload_t   (ucpd_pkg::tx_status_t)
  ) u_tx_sync (
    .pclk     (pclk),
    .presetn  (presetn),
    .async_in (tx_status),
    .rise     (tx_rise)
  );

  ucpd_flag_sync #(
    .SYNC_STAGES (SYNC_STAGES),
    .payload_t   (ucpd_pkg::rx_status_t)
  ) u_rx_sync (
    .pclk     (pclk),
    .presetn  (presetn),
    .async_in (rx_status),
    .rise     (rx_rise)
  );

  ucpd_flag_sync #(
    .SYNC_STAGES (SYNC_STAGES),
    .payload_t   (logic)
  ) u_frs_sync (
    .pclk     (pclk),
    .presetn  (presetn),
    .async_in (frs_evt),
    .rise     (frs_rise)
  );

  ucpd_cc_vstate u_cc1_vstate (
    .pclk      (pclk),
    .presetn   (presetn),
    .comp      (cc1_compout),
    .source_en (ana_ctrl.source_en),
    .vstate    (cc1_vstate),
    .change    (cc1_change)
  );

  ucpd_cc_vstate u_cc2_vstate (
    .pclk      (pclk),
    .presetn   (presetn),
    .comp      (cc2_compout),
    .source_en (ana_ctrl.source_en),
    .vstate    (cc2_vstate),
    .change    (cc2_change)
  );

  // ----------------------------------------------------------
  // SR and read back
  // ----------------------------------------------------------
  ucpd_status_regs u_status (
    .pclk       (pclk),
    .presetn    (presetn),
    .tx_rise    (tx_rise),
    .rx_rise    (rx_rise),
    .frs_rise   (frs_rise),
    .cc1_vstate (cc1_vstate),
    .cc2_vstate (cc2_vstate),
    .cc1_change (cc1_change),
    .cc2_change (cc2_change),
    .icr_we     (wr_sel.icr),
    .pwdata     (pwdata),
    .sr_word    (sr_word)
  );

  ucpd_read_mux u_rdmux (
    .sel       (sel),
    .cfg1_word (cfg1_word),
    .cr_word   (cr_word),
    .imr_word  (imr_word),
    .sr_word   (sr_word),
    .prdata    (prdata),
    .ucpd_intr (ucpd_intr)
  );

endmodule

`default_nettype wire

/* verilog/ucpd_status_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module ucpd_status_regs (
  input  wire                       pclk,
  input  wire                       presetn,
  input  wire ucpd_pkg::tx_status_t tx_rise,
  input  wire ucpd_pkg::rx_status_t rx_rise,
  input  wire                       frs_rise,
  input  wire ucpd_pkg::vstate_t    cc1_vstate,
  input  wire ucpd_pkg::vstate_t    cc2_vstate,
  input  wire                       cc1_change,
  input  wire                       cc2_change,
  input  wire                       icr_we,
  input  wire ucpd_pkg::reg_word_t  pwdata,
  output ucpd_pkg::reg_word_t       sr_word
);

  ucpd_pkg::reg_word_t evt_set;
  ucpd_pkg::reg_word_t evt_clr;

  // ----------------------------------------------------------
  // Event set and clear vectors in SR bit order
  // ----------------------------------------------------------
  always_comb
  begin
    evt_set = '0;
    evt_set[ucpd_pkg::SR_TX_HI:ucpd_pkg::SR_TX_LO] = tx_rise;
    evt_set[ucpd_pkg::SR_RX_HI:ucpd_pkg::SR_RX_LO] = rx_rise;
    evt_set[ucpd_pkg::SR_TYPECEVT1] = cc1_change;
    evt_set[ucpd_pkg::SR_TYPECEVT2] = cc2_change;
    evt_set[ucpd_pkg::SR_FRSEVT]    = frs_rise;
  end

  // ICR bits clear the matching flags
  assign evt_clr = icr_we ? pwdata : '0;

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      sr_word <= '0;
    else
    begin
      // Clear wins over a set in the same cycle
      sr_word <= (sr_word | evt_set) & ~evt_clr;
      // Voltage state follows the CC pins
      sr_word[ucpd_pkg::SR_VSTATE1_LO +: 2] <= cc1_vstate;
      sr_word[ucpd_pkg::SR_VSTATE2_LO +: 2] <= cc2_vstate;
    end
  end

endmodule

`default_nettype wire
